// File: dcache_config.svh
//////////////////////////////
// Sizing macros for the data cache
// Line count and words per line must be powers of two
// Tag width must equal address width minus the line offset bits
// There is no base-address window, so every address is cacheable
//////////////////////////////

`ifndef DCACHE_CONFIG_SVH
`define DCACHE_CONFIG_SVH

// CPU and memory address width
`define DC_ADDR_W      32

// Data word width, byte lanes follow from it
`define DC_DATA_W      32

// Number of cache lines, FIFO replaced
`define DC_LINES       4

// Words per line, also the burst length
`define DC_LINE_WORDS  8

// Tag taken from address bits 31 to 5
`define DC_TAG_W       27

`endif

// File: dcache_pkg.sv
//////////////////////////////
// Shared types of the data cache
// Widths follow the config macros
// Width and command encodings follow the CPU port
//////////////////////////////

`include "dcache_config.svh"

package dcache_pkg;

    // Derived sizes
    localparam int DC_LINE_IDX_W = $clog2(`DC_LINES);
    localparam int DC_WORD_IDX_W = $clog2(`DC_LINE_WORDS);
    localparam int DC_RAM_DEPTH  = `DC_LINES * `DC_LINE_WORDS;
    localparam int DC_BE_W       = `DC_DATA_W / 8;
    localparam int DC_OFS_W      = `DC_ADDR_W - `DC_TAG_W;

    // Access width as driven by the CPU
    typedef enum logic [1:0] {
        BYTE = 2'b00,
        HALF = 2'b01,
        WORD = 2'b10
    } dc_width_e;

    typedef enum logic {
        CMD_READ  = 1'b0,
        CMD_WRITE = 1'b1
    } dc_cmd_e;

    // Controller FSM states
    typedef enum logic [2:0] {
        IDLE,
        TAG_CHECK,
        READ_WAIT,
        WB_READ,
        WB_BURST,
        REFILL_REQ,
        REFILL
    } dc_state_e;

    typedef logic [DC_LINE_IDX_W-1:0]               dc_line_idx_t;
    typedef logic [DC_WORD_IDX_W-1:0]               dc_word_idx_t;
    // Line index in the upper bits, word index below
    typedef logic [DC_LINE_IDX_W+DC_WORD_IDX_W-1:0] dc_ram_addr_t;

    typedef struct packed {
        dc_cmd_e                cmd;
        logic [`DC_ADDR_W-1:0]  addr;
        dc_width_e              width;
        logic [`DC_DATA_W-1:0]  wdata;
    } dc_cpu_req_t;

    typedef struct packed {
        dc_cmd_e                cmd;
        dc_width_e              width;
        logic [`DC_TAG_W-1:0]   tag;
        dc_word_idx_t           word;
        logic [1:0]             byte_ofs;
        logic [DC_BE_W-1:0]     be;
        // Already replicated onto the addressed lanes
        logic [`DC_DATA_W-1:0]  wdata;
    } dc_dec_req_t;

    typedef struct packed {
        logic                   valid;
        logic                   dirty;
        logic [`DC_TAG_W-1:0]   tag;
    } dc_tag_entry_t;

    typedef struct packed {
        logic                   hit;
        dc_line_idx_t           hit_idx;
        dc_line_idx_t           victim_idx;
        dc_tag_entry_t          victim;
        logic                   full;
    } dc_tag_look_t;

endpackage

// File: dcache_req_decode.sv
//////////////////////////////
// Request latch and decode
// Holds the accepted request until the next accept
// Width code 2'b11 is treated as a word access
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_req_decode (
    input  logic                     mclk,
    input  logic                     rst_n,
    input  logic                     accept_i,
    input  dcache_pkg::dc_cpu_req_t  req_i,
    output dcache_pkg::dc_dec_req_t  dec_o
);
    import dcache_pkg::*;

    dc_dec_req_t dec_d;

    always_comb begin
        dec_d.cmd      = req_i.cmd;
        dec_d.width    = req_i.width;
        // Split the address into tag, word in line and byte in word
        dec_d.tag      = req_i.addr[`DC_ADDR_W-1 -: `DC_TAG_W];
        dec_d.word     = req_i.addr[DC_OFS_W-1 -: DC_WORD_IDX_W];
        dec_d.byte_ofs = req_i.addr[1:0];
        // Lane enables, write data copied onto every lane
        case (req_i.width)
            BYTE: begin
                dec_d.be    = 4'b0001 << req_i.addr[1:0];
                dec_d.wdata = {4{req_i.wdata[7:0]}};
            end
            HALF: begin
                dec_d.be    = 4'b0011 << {req_i.addr[1], 1'b0};
                dec_d.wdata = {2{req_i.wdata[15:0]}};
            end
            default: begin
                dec_d.be    = '1;
                dec_d.wdata = req_i.wdata;
            end
        endcase
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            dec_o <= '0;
        end else if (accept_i) begin
            dec_o <= dec_d;
        end
    end

endmodule

// File: dcache_tag_store.sv
//////////////////////////////
// Tag store with FIFO replacement
// Lines are allocated in order 0,1,2,3 and then reused in the same order
// Full stays set once every line has been allocated
// Hit compare is purely combinational on cmp_tag_i
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_tag_store (
    input  logic                        mclk,
    input  logic                        rst_n,
    input  logic                        wr_i,
    input  dcache_pkg::dc_tag_entry_t   wr_entry_i,
    input  dcache_pkg::dc_line_idx_t    wr_idx_i,
    input  logic                        alloc_i,
    input  logic [`DC_TAG_W-1:0]        cmp_tag_i,
    output dcache_pkg::dc_tag_look_t    look_o
);
    import dcache_pkg::*;

    dc_tag_entry_t  ent_q [`DC_LINES];
    dc_line_idx_t   ptr_q;
    logic           full_q;

    // Entry update and FIFO pointer
    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `DC_LINES; i++) begin
                ent_q[i] <= '0;
            end
            ptr_q  <= '0;
            full_q <= 1'b0;
        end else begin
            if (wr_i) begin
                ent_q[wr_idx_i] <= wr_entry_i;
            end
            if (alloc_i) begin
                ptr_q <= ptr_q + 1'b1;
                // Last free line just taken
                if (ptr_q == dc_line_idx_t'(`DC_LINES - 1)) begin
                    full_q <= 1'b1;
                end
            end
        end
    end

    // Parallel compare over all valid entries
    always_comb begin
        look_o.hit     = 1'b0;
        look_o.hit_idx = '0;
        for (int i = 0; i < `DC_LINES; i++) begin
            if (ent_q[i].valid && (ent_q[i].tag == cmp_tag_i)) begin
                look_o.hit     = 1'b1;
                look_o.hit_idx = dc_line_idx_t'(i);
            end
        end
        // Victim is always the oldest allocation
        look_o.victim_idx = ptr_q;
        look_o.victim     = ent_q[ptr_q];
        look_o.full       = full_q;
    end

endmodule

// File: dcache_data_ram.sv
//////////////////////////////
// Single-port data RAM, 32 words
// Read data registered one cycle after the address
// Read data holds its value while no read is enabled
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_data_ram (
    input  logic                            mclk,
    input  logic                            en_i,
    input  logic                            we_i,
    input  logic [dcache_pkg::DC_BE_W-1:0]  mask_i,
    input  dcache_pkg::dc_ram_addr_t        addr_i,
    input  logic [`DC_DATA_W-1:0]           wdata_i,
    output logic [`DC_DATA_W-1:0]           rdata_o
);
    import dcache_pkg::*;

    logic [`DC_DATA_W-1:0] mem_q [DC_RAM_DEPTH];

    always_ff @(posedge mclk) begin
        if (en_i) begin
            if (we_i) begin
                // Byte lane write
                for (int b = 0; b < DC_BE_W; b++) begin
                    if (mask_i[b]) begin
                        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
                    end
                end
            end else begin
                rdata_o <= mem_q[addr_i];
            end
        end
    end

endmodule

// File: dcache_ctrl.sv
//////////////////////////////
// Cache controller FSM
// One request at a time, accepted only in IDLE
// Bursts are one full line in ascending word order
// A dirty victim is written out before its line is refilled
// Memory may stall any number of cycles between acks
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_ctrl (
    input  logic                            mclk,
    input  logic                            rst_n,
    input  logic                            cpu_req_i,
    input  logic                            resp_busy_i,
    output logic                            cpu_req_ack_o,
    input  dcache_pkg::dc_dec_req_t         dec_i,
    input  dcache_pkg::dc_tag_look_t        look_i,
    output logic                            tag_wr_o,
    output dcache_pkg::dc_line_idx_t        tag_idx_o,
    output dcache_pkg::dc_tag_entry_t       tag_entry_o,
    output logic                            tag_alloc_o,
    output logic                            ram_en_o,
    output logic                            ram_we_o,
    output logic [dcache_pkg::DC_BE_W-1:0]  ram_mask_o,
    output dcache_pkg::dc_ram_addr_t        ram_addr_o,
    output logic [`DC_DATA_W-1:0]           ram_wdata_o,
    input  logic [`DC_DATA_W-1:0]           ram_rdata_i,
    output logic                            mem_stb_o,
    output logic                            mem_we_o,
    output logic [`DC_ADDR_W-1:0]           mem_adr_o,
    output logic [`DC_DATA_W-1:0]           mem_dat_o,
    input  logic [`DC_DATA_W-1:0]           mem_dat_i,
    input  logic                            mem_ack_i,
    input  logic                            mem_lack_i,
    output logic                            deliver_o,
    output logic [`DC_DATA_W-1:0]           deliver_word_o
);
    import dcache_pkg::*;

    dc_state_e              state_q;
    dc_state_e              state_d;
    dc_word_idx_t           wd_q;
    logic [`DC_DATA_W-1:0]  hold_q;
    logic                   is_wr;
    logic                   need_wb;
    logic                   word_hit;
    logic                   hold_ld;
    logic [`DC_DATA_W-1:0]  merged;

    assign is_wr    = (dec_i.cmd == CMD_WRITE);
    assign need_wb  = look_i.full && look_i.victim.valid && look_i.victim.dirty;
    // Burst word is the one the CPU asked for
    assign word_hit = (wd_q == dec_i.word);

    // CPU bytes laid over the refill word
    always_comb begin
        merged = mem_dat_i;
        for (int b = 0; b < DC_BE_W; b++) begin
            if (is_wr && word_hit && dec_i.be[b]) begin
                merged[b*8 +: 8] = dec_i.wdata[b*8 +: 8];
            end
        end
    end

    ////////////////////////////////
    // Next state and strobes
    ////////////////////////////////
    always_comb begin
        state_d           = state_q;
        cpu_req_ack_o     = 1'b0;
        tag_wr_o          = 1'b0;
        tag_idx_o         = look_i.victim_idx;
        tag_entry_o.valid = 1'b1;
        tag_entry_o.dirty = is_wr;
        tag_entry_o.tag   = dec_i.tag;
        tag_alloc_o       = 1'b0;
        ram_en_o          = 1'b0;
        ram_we_o          = 1'b0;
        ram_mask_o        = '1;
        ram_addr_o        = {look_i.victim_idx, wd_q};
        ram_wdata_o       = merged;
        deliver_o         = 1'b0;
        deliver_word_o    = mem_dat_i;
        case (state_q)
            IDLE: begin
                // Hold off while a response leaves this cycle
                cpu_req_ack_o = cpu_req_i && !resp_busy_i;
                if (cpu_req_ack_o) begin
                    state_d = TAG_CHECK;
                end
            end
            TAG_CHECK: begin
                if (look_i.hit) begin
                    ram_en_o   = 1'b1;
                    ram_addr_o = {look_i.hit_idx, dec_i.word};
                    if (is_wr) begin
                        // Write hit marks the line dirty and completes now
                        ram_we_o    = 1'b1;
                        ram_mask_o  = dec_i.be;
                        ram_wdata_o = dec_i.wdata;
                        tag_wr_o    = 1'b1;
                        tag_idx_o   = look_i.hit_idx;
                        deliver_o   = 1'b1;
                        state_d     = IDLE;
                    end else begin
                        state_d = READ_WAIT;
                    end
                end else if (need_wb) begin
                    state_d = WB_READ;
                end else begin
                    state_d = REFILL_REQ;
                end
            end
            READ_WAIT: begin
                deliver_o      = 1'b1;
                deliver_word_o = ram_rdata_i;
                state_d        = IDLE;
            end
            WB_READ: begin
                // Words 0 and 1 fetched ahead of the strobe
                ram_en_o = 1'b1;
                if (wd_q == dc_word_idx_t'(1)) begin
                    state_d = WB_BURST;
                end
            end
            WB_BURST: begin
                // Each ack pulls the following victim word
                ram_en_o = mem_ack_i;
                if (mem_lack_i) begin
                    state_d = REFILL_REQ;
                end
            end
            REFILL_REQ: begin
                state_d = REFILL;
            end
            REFILL: begin
                if (mem_ack_i) begin
                    ram_en_o  = 1'b1;
                    ram_we_o  = 1'b1;
                    deliver_o = word_hit;
                end
                // New tag goes in with the last word
                if (mem_lack_i) begin
                    tag_wr_o    = 1'b1;
                    tag_alloc_o = 1'b1;
                    state_d     = IDLE;
                end
            end
            default: begin
                state_d = IDLE;
            end
        endcase
    end

    assign mem_stb_o = (state_q == WB_BURST) || (state_q == REFILL);
    assign mem_we_o  = (state_q == WB_BURST);
    assign mem_adr_o = {mem_we_o ? look_i.victim.tag : dec_i.tag, {DC_OFS_W{1'b0}}};
    assign mem_dat_o = hold_q;

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            state_q <= IDLE;
            wd_q    <= '0;
        end else begin
            state_q <= state_d;
            if (state_q == REFILL_REQ) begin
                wd_q <= '0;
            end else if ((state_q == WB_READ) || (mem_stb_o && mem_ack_i)) begin
                wd_q <= wd_q + 1'b1;
            end
        end
    end

    // Hold register keeps the write word stable across ack gaps
    assign hold_ld = ((state_q == WB_READ) && (state_d == WB_BURST))
                   || ((state_q == WB_BURST) && mem_ack_i);

    always_ff @(posedge mclk) begin
        if (hold_ld) begin
            hold_q <= ram_rdata_i;
        end
    end

endmodule

// File: dcache_resp_align.sv
//////////////////////////////
// Result stage
// Response pulse comes one cycle after the deliver strobe
// Byte and halfword reads return zero-filled upper bits
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_resp_align (
    input  logic                     mclk,
    input  logic                     rst_n,
    input  logic                     deliver_i,
    input  logic [`DC_DATA_W-1:0]    word_i,
    input  dcache_pkg::dc_dec_req_t  dec_i,
    output logic                     busy_o,
    output logic                     cpu_resp_o,
    output logic [`DC_DATA_W-1:0]    cpu_rdata_o
);
    import dcache_pkg::*;

    logic [`DC_DATA_W-1:0] lane_word;
    logic [`DC_DATA_W-1:0] shifted;

    // Addressed lane moved down to bit 0
    assign shifted = word_i >> {dec_i.byte_ofs, 3'b000};

    always_comb begin
        case (dec_i.width)
            BYTE:    lane_word = {{(`DC_DATA_W-8){1'b0}}, shifted[7:0]};
            HALF:    lane_word = {{(`DC_DATA_W-16){1'b0}}, shifted[15:0]};
            default: lane_word = word_i;
        endcase
    end

    always_ff @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            cpu_resp_o <= 1'b0;
        end else begin
            cpu_resp_o <= deliver_i;
        end
    end

    always_ff @(posedge mclk) begin
        if (deliver_i) begin
            cpu_rdata_o <= lane_word;
        end
    end

    // Blocks a new accept while the pulse is out
    assign busy_o = cpu_resp_o;

endmodule

// File: dcache_top.sv
//////////////////////////////
// Write-back data cache, 4 lines of 8 words
// CPU holds request fields stable until cpu_req_ack_o
// Memory side bursts one full line per strobe
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_top (
    input  logic                     mclk,
    input  logic                     rst_n,
    // CPU load/store port
    input  logic                     cpu_req_i,
    input  dcache_pkg::dc_cpu_req_t  cpu_req_o,
    output logic                     cpu_req_ack_o,
    output logic                     cpu_resp_o,
    output logic [`DC_DATA_W-1:0]    cpu_rdata_o,
    // Main memory burst port
    output logic                     mem_stb_o,
    output logic                     mem_we_o,
    output logic [`DC_ADDR_W-1:0]    mem_adr_o,
    output logic [`DC_DATA_W-1:0]    mem_dat_o,
    input  logic [`DC_DATA_W-1:0]    mem_dat_i,
    input  logic                     mem_ack_i,
    input  logic                     mem_lack_i
);
    import dcache_pkg::*;

    dc_dec_req_t            dec;
    dc_tag_look_t           look;
    logic                   tag_wr;
    dc_line_idx_t           tag_idx;
    dc_tag_entry_t          tag_entry;
    logic                   tag_alloc;
    logic                   ram_en;
    logic                   ram_we;
    logic [DC_BE_W-1:0]     ram_mask;
    dc_ram_addr_t           ram_addr;
    logic [`DC_DATA_W-1:0]  ram_wdata;
    logic [`DC_DATA_W-1:0]  ram_rdata;
    logic                   deliver;
    logic [`DC_DATA_W-1:0]  deliver_word;
    logic                   resp_busy;

    dcache_req_decode u_decode (
        .mclk     (mclk),
        .rst_n    (rst_n),
        .accept_i (cpu_req_ack_o),
        .req_i    (cpu_req_o),
        .dec_o    (dec)
    );

    dcache_tag_store u_tags (
        .mclk       (mclk),
        .rst_n      (rst_n),
        .wr_i       (tag_wr),
        .wr_entry_i (tag_entry),
        .wr_idx_i   (tag_idx),
        .alloc_i    (tag_alloc),
        .cmp_tag_i  (dec.tag),
        .look_o     (look)
    );

    dcache_data_ram u_ram (
        .mclk    (mclk),
        .en_i    (ram_en),
        .we_i    (ram_we),
        .mask_i  (ram_mask),
        .addr_i  (ram_addr),
        .wdata_i (ram_wdata),
        .rdata_o (ram_rdata)
    );

    dcache_ctrl u_ctrl (
        .mclk           (mclk),
        .rst_n          (rst_n),
        .cpu_req_i      (cpu_req_i),
        .resp_busy_i    (resp_busy),
        .cpu_req_ack_o  (cpu_req_ack_o),
        .dec_i          (dec),
        .look_i         (look),
        .tag_wr_o       (tag_wr),
        .tag_idx_o      (tag_idx),
        .tag_entry_o    (tag_entry),
        .tag_alloc_o    (tag_alloc),
        .ram_en_o       (ram_en),
        .ram_we_o       (ram_we),
        .ram_mask_o     (ram_mask),
        .ram_addr_o     (ram_addr),
        .ram_wdata_o    (ram_wdata),
        .ram_rdata_i    (ram_rdata),
        .mem_stb_o      (mem_stb_o),
        .mem_we_o       (mem_we_o),
        .mem_adr_o      (mem_adr_o),
        .mem_dat_o      (mem_dat_o),
        .mem_dat_i      (mem_dat_i),
        .mem_ack_i      (mem_ack_i),
        .mem_lack_i     (mem_lack_i),
        .deliver_o      (deliver),
        .deliver_word_o (deliver_word)
    );

    dcache_resp_align u_resp (
        .mclk        (mclk),
        .rst_n       (rst_n),
        .deliver_i   (deliver),
        .word_i      (deliver_word),
        .dec_i       (dec),
        .busy_o      (resp_busy),
        .cpu_resp_o  (cpu_resp_o),
        .cpu_rdata_o (cpu_rdata_o)
    );

endmodule

// File: dcache_mem_model.sv
//////////////////////////////
// Main memory model for the testbench
// Unwritten words read as address XOR 32'h5a5a0000
// Acks come 0 to 2 idle cycles apart, one burst per strobe
// Burst address must be line aligned
//////////////////////////////

`timescale 1ns/10ps

module dcache_mem_model (
    input  logic        mclk,
    input  logic        rst_n,
    input  logic        stb_i,
    input  logic        we_i,
    input  logic [31:0] adr_i,
    input  logic [31:0] dat_i,
    output logic [31:0] dat_o,
    output logic        ack_o,
    output logic        lack_o,
    output logic [7:0]  wr_bursts_o
);
    logic [31:0] store [logic [31:0]];
    logic [2:0]  cnt_q;
    logic [2:0]  ack_idx_q;
    logic        done_q;
    logic [1:0]  gap_q;
    logic [31:0] lfsr_q;
    logic [31:0] lfsr_s1;
    logic [31:0] lfsr_s2;

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (store.exists(a)) begin
            return store[a];
        end
        return a ^ 32'h5a5a_0000;
    endfunction

    always @(posedge mclk or negedge rst_n) begin
        if (!rst_n) begin
            ack_o       <= 1'b0;
            lack_o      <= 1'b0;
            dat_o       <= '0;
            cnt_q       <= '0;
            ack_idx_q   <= '0;
            done_q      <= 1'b0;
            gap_q       <= '0;
            lfsr_q      <= 32'h993b;
            wr_bursts_o <= '0;
        end else begin
            ack_o  <= 1'b0;
            lack_o <= 1'b0;
            // Write word is valid in the ack cycle
            if (ack_o && we_i) begin
                store[{adr_i[31:5], ack_idx_q, 2'b00}] = dat_i;
            end
            if (lack_o && we_i) begin
                wr_bursts_o <= wr_bursts_o + 8'd1;
            end
            if (!stb_i) begin
                cnt_q  <= '0;
                done_q <= 1'b0;
            end else if (!done_q) begin
                if (gap_q != 2'd0) begin
                    gap_q <= gap_q - 2'd1;
                end else begin
                    ack_o     <= 1'b1;
                    dat_o     <= read_word({adr_i[31:5], cnt_q, 2'b00});
                    ack_idx_q <= cnt_q;
                    cnt_q     <= cnt_q + 3'd1;
                    if (cnt_q == 3'd7) begin
                        lack_o <= 1'b1;
                        done_q <= 1'b1;
                    end
                    // Two bits taken for the next gap
                    lfsr_s1 = lfsr_step(lfsr_q);
                    lfsr_s2 = lfsr_step(lfsr_s1);
                    gap_q   <= 2'(({lfsr_s1[0], lfsr_q[0]}) % 3);
                    lfsr_q  <= lfsr_s2;
                end
            end
        end
    end

endmodule

// File: dcache_tb.sv
//////////////////////////////
// Testbench for the data cache
// Reads accesses from dcache_trace.txt in the project root
// Latency column 0 skips the timing check and write burst column ff skips the count
//////////////////////////////

`timescale 1ns/10ps
`include "dcache_config.svh"

module dcache_tb;
    import dcache_pkg::*;

    logic                  mclk;
    logic                  rst_n;
    logic                  cpu_req;
    dc_cpu_req_t           cpu_req_f;
    logic                  cpu_req_ack;
    logic                  cpu_resp;
    logic [`DC_DATA_W-1:0] cpu_rdata;
    logic                  mem_stb;
    logic                  mem_we;
    logic [`DC_ADDR_W-1:0] mem_adr;
    logic [`DC_DATA_W-1:0] mem_dat_w;
    logic [`DC_DATA_W-1:0] mem_dat_r;
    logic                  mem_ack;
    logic                  mem_lack;
    logic [7:0]            wr_bursts;

    int errors;
    int tests;
    int failed_tests;
    int abort;

    dcache_top dut (
        .mclk          (mclk),
        .rst_n         (rst_n),
        .cpu_req_i     (cpu_req),
        .cpu_req_o     (cpu_req_f),
        .cpu_req_ack_o (cpu_req_ack),
        .cpu_resp_o    (cpu_resp),
        .cpu_rdata_o   (cpu_rdata),
        .mem_stb_o     (mem_stb),
        .mem_we_o      (mem_we),
        .mem_adr_o     (mem_adr),
        .mem_dat_o     (mem_dat_w),
        .mem_dat_i     (mem_dat_r),
        .mem_ack_i     (mem_ack),
        .mem_lack_i    (mem_lack)
    );

    dcache_mem_model u_mem (
        .mclk        (mclk),
        .rst_n       (rst_n),
        .stb_i       (mem_stb),
        .we_i        (mem_we),
        .adr_i       (mem_adr),
        .dat_i       (mem_dat_w),
        .dat_o       (mem_dat_r),
        .ack_o       (mem_ack),
        .lack_o      (mem_lack),
        .wr_bursts_o (wr_bursts)
    );

    initial mclk = 1'b0;
    always #10 mclk = ~mclk;

    // Single output that must be low while idle
    task automatic check_idle_low(input string name, input logic value);
        if (value !== 1'b0) begin
            $display("FAIL t=%0t %s expected 0 got %b", $time, name, value);
            errors++;
        end
    endtask

    ////////////////////////////////
    // One CPU access with checks
    ////////////////////////////////
    task automatic run_access(input logic cmd, input logic [1:0] width,
                              input logic [31:0] addr, input logic [31:0] wdata,
                              input logic [31:0] exp, input logic [7:0] lat,
                              input logic [7:0] wb);
        int t;
        int cyc;
        int err_in;
        logic got;
        logic refill_seen;
        logic [7:0] refill_wb;
        err_in      = errors;
        refill_seen = 1'b0;
        refill_wb   = '0;
        tests++;
        @(negedge mclk);
        cpu_req         = 1'b1;
        cpu_req_f.cmd   = dc_cmd_e'(cmd);
        cpu_req_f.width = dc_width_e'(width);
        cpu_req_f.addr  = addr;
        cpu_req_f.wdata = wdata;
        // Ack is combinational and is sampled just after the drive edge
        t   = 0;
        got = 1'b0;
        while (!got && t < 200) begin
            #1;
            if (cpu_req_ack) begin
                got = 1'b1;
            end else begin
                @(negedge mclk);
                t++;
            end
        end
        if (!got) begin
            $display("test %0d: no request ack within 200 cycles", tests);
            errors++;
            failed_tests++;
            abort = 1;
            return;
        end
        @(negedge mclk);
        cpu_req = 1'b0;
        cyc     = 1;
        while (!cpu_resp && cyc < 500) begin
            // Write burst count as the refill strobe first shows
            if (mem_stb && !mem_we && !refill_seen) begin
                refill_seen = 1'b1;
                refill_wb   = wr_bursts;
            end
            @(negedge mclk);
            cyc++;
        end
        if (!cpu_resp) begin
            $display("test %0d: no response within 500 cycles of accept", tests);
            errors++;
            failed_tests++;
            abort = 1;
            return;
        end
        if (cmd == 1'b0 && cpu_rdata !== exp) begin
            $display("FAIL t=%0t cpu_rdata_o expected %h got %h", $time, exp, cpu_rdata);
            errors++;
        end
        if (lat != 8'd0 && cyc != int'(lat)) begin
            $display("FAIL t=%0t cpu_resp_o latency expected %0d got %0d", $time, lat, cyc);
            errors++;
        end
        if (wb != 8'hff && wr_bursts !== wb) begin
            $display("FAIL t=%0t wr_bursts_o expected %0d got %0d", $time, wb, wr_bursts);
            errors++;
        end
        // Victim write-back must be finished before the refill strobe
        if (wb != 8'hff && refill_seen && refill_wb !== wb) begin
            $display("FAIL t=%0t wr_bursts_o at refill expected %0d got %0d",
                     $time, wb, refill_wb);
            errors++;
        end
        if (errors != err_in) begin
            failed_tests++;
            $display("test %0d addr %h: FAIL", tests, addr);
        end else begin
            $display("test %0d addr %h: ok", tests, addr);
        end
    endtask

    initial begin
        int fd;
        int n;
        string line;
        logic [31:0] f_cmd;
        logic [31:0] f_width;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        logic [31:0] f_lat;
        logic [31:0] f_wb;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;
        abort        = 0;
        rst_n        = 1'b0;
        cpu_req      = 1'b0;
        cpu_req_f    = '0;
        repeat (16) @(posedge mclk);
        @(negedge mclk);
        rst_n = 1'b1;
        @(negedge mclk);
        // Idle outputs after reset
        check_idle_low("cpu_req_ack_o", cpu_req_ack);
        check_idle_low("cpu_resp_o", cpu_resp);
        check_idle_low("mem_stb_o", mem_stb);
        check_idle_low("mem_we_o", mem_we);
        fd = $fopen("dcache_trace.txt", "r");
        if (fd == 0) begin
            $display("could not open dcache_trace.txt");
            errors++;
            abort = 1;
        end
        while (!abort && !$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %h %h",
                            f_cmd, f_width, f_addr, f_wdata, f_exp, f_lat, f_wb);
                if (n == 7) begin
                    run_access(f_cmd[0], f_width[1:0], f_addr, f_wdata, f_exp,
                               f_lat[7:0], f_wb[7:0]);
                end
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end
        $display("tests %0d, failed tests %0d, failed checks %0d",
                 tests, failed_tests, errors);
        if (errors == 0 && tests > 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

// File: dcache_trace.txt
# cmd(0 rd,1 wr) width(0 byte,1 half,2 word) addr wdata exp_rdata
# latency(0 = no check) write_bursts(ff = no check), all hex
0 2 00000000 00000000 5a5a0000 0 00
0 2 00000004 00000000 5a5a0004 3 ff
1 2 00000008 11223344 00000000 2 ff
0 2 00000008 00000000 11223344 3 ff
1 0 0000000d 000000aa 00000000 2 ff
0 2 0000000c 00000000 5a5aaa0c 3 ff
1 0 00000013 00000077 00000000 2 ff
0 2 00000010 00000000 775a0010 3 ff
1 0 0000001e 0000003c 00000000 2 ff
0 2 0000001c 00000000 5a3c001c 3 ff
1 1 00000016 0000beef 00000000 2 ff
0 2 00000014 00000000 beef0014 3 ff
1 1 00000018 0000cafe 00000000 2 ff
0 2 00000018 00000000 5a5acafe 3 ff
0 0 0000000d 00000000 000000aa 3 ff
0 1 00000016 00000000 0000beef 3 ff
0 0 00000013 00000000 00000077 3 ff
1 1 00000022 00001234 00000000 0 00
0 2 00000020 00000000 12340020 3 00
0 2 00000044 00000000 5a5a0044 0 00
0 2 0000006c 00000000 5a5a006c 0 00
0 2 00000080 00000000 5a5a0080 0 01
0 2 0000000c 00000000 5a5aaa0c 0 02
0 2 00000014 00000000 beef0014 3 02
0 2 000000a0 00000000 5a5a00a0 0 02

// File: compile.f
+incdir+.
dcache_pkg.sv
dcache_req_decode.sv
dcache_tag_store.sv
dcache_data_ram.sv
dcache_ctrl.sv
dcache_resp_align.sv
dcache_top.sv
dcache_mem_model.sv
dcache_tb.sv

// File: Makefile
.PHONY: compile run clean

compile:
	verilator --binary --timing -f compile.f --top-module dcache_tb -Mdir obj_dir

run: compile
	./obj_dir/Vdcache_tb | tee /dev/stderr | grep -q "SIMULATION PASSED"

clean:
	rm -rf obj_dir
